//--- lsu_pkg.sv
package lsu_pkg;

  // datapath sizes
  localparam int data_width = 32;  // address, store data, load result
  localparam int mem_words  = 256; // depth of the data memory
  localparam int mem_aw     = 8;   // word index, taken from addr[9:2]

  // operation class carried with every request
  localparam int op_w = 2;

  localparam logic [op_w-1:0] op_none  = 2'd0;
  localparam logic [op_w-1:0] op_load  = 2'd1;
  localparam logic [op_w-1:0] op_store = 2'd2;
  // code 3 is unused and is treated as illegal, the same as op_none

  // RV32 funct3 for loads and stores
  // loads accept all five codes
  // stores only use the signed ones: sb, sh, sw
  localparam logic [2:0] f3_b  = 3'd0; // lb / sb
  localparam logic [2:0] f3_h  = 3'd1; // lh / sh
  localparam logic [2:0] f3_w  = 3'd2; // lw / sw
  localparam logic [2:0] f3_bu = 3'd4; // lbu
  localparam logic [2:0] f3_hu = 3'd5; // lhu

  // everything else (3, 6, 7) raises the error flag

endpackage

//--- lsu_req_port.sv
module lsu_req_port import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  output logic                  ack,
  input  logic [op_w-1:0]       lsu_op,
  input  logic [2:0]            funct3,
  input  logic [data_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic                  cmd_ready,
  output logic                  cmd_valid,
  output logic [op_w-1:0]       cmd_op,
  output logic [2:0]            cmd_funct3,
  output logic [data_width-1:0] cmd_addr,
  output logic [data_width-1:0] cmd_wdata
);

  typedef enum logic {
    st_idle,
    st_acked
  } state_t;

  state_t state;
  logic   accept;

  // take a new request only when the core can start it right away
  assign accept = (state == st_idle) && req && cmd_ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= st_idle;
      cmd_valid <= 1'b0;
    end else begin
      cmd_valid <= accept; // single cycle pulse, same edge as ack
      case (state)
        st_idle: begin
          if (accept) state <= st_acked;
        end
        st_acked: begin
          if (!req) state <= st_idle; // requester released, drop ack
        end
        default: state <= st_idle;
      endcase
    end
  end

  // operation fields, held while the core works on them
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_op     <= lsu_op;
      cmd_funct3 <= funct3;
      cmd_addr   <= addr;
      cmd_wdata  <= wdata;
    end
  end

  assign ack = (state == st_acked);

  // four-phase rule on the requester link
  a_ack_hold: assert property (@(posedge clk) disable iff (!rst_n)
    ack && req |=> ack)
    else $error("ack dropped while req was still high");

endmodule

//--- lsu_align.sv
module lsu_align import lsu_pkg::*; (
  input  logic [op_w-1:0]       op,
  input  logic [2:0]            funct3,
  input  logic [data_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  input  logic [data_width-1:0] rdata,
  output logic [3:0]            wr_be,
  output logic [data_width-1:0] wr_data,
  output logic [data_width-1:0] ld_result,
  output logic                  err
);

  logic [1:0]  off;     // byte offset inside the word
  logic [7:0]  ld_byte;
  logic [15:0] ld_half;

  assign off = addr[1:0];

  // legality of class, funct3 and alignment
  always_comb begin
    err = 1'b1;
    case (op)
      op_load: begin
        case (funct3)
          f3_b, f3_bu: err = 1'b0;
          f3_h, f3_hu: err = off[0];
          f3_w:        err = |off;
          default:     err = 1'b1;
        endcase
      end
      op_store: begin
        case (funct3)
          f3_b:    err = 1'b0;
          f3_h:    err = off[0];
          f3_w:    err = |off;
          default: err = 1'b1; // no unsigned stores
        endcase
      end
      default: err = 1'b1; // op_none and the spare code
    endcase
  end

  // store data replicated on all lanes, be picks the live ones
  always_comb begin
    case (funct3)
      f3_b:    wr_data = {4{wdata[7:0]}};
      f3_h:    wr_data = {2{wdata[15:0]}};
      default: wr_data = wdata;
    endcase
  end

  always_comb begin
    wr_be = 4'b0000;
    if (op == op_store && !err) begin
      case (funct3)
        f3_b:    wr_be = 4'b0001 << off;
        f3_h:    wr_be = 4'b0011 << off;
        default: wr_be = 4'b1111;
      endcase
    end
  end

  // load lane select
  always_comb begin
    case (off)
      2'd0:    ld_byte = rdata[7:0];
      2'd1:    ld_byte = rdata[15:8];
      2'd2:    ld_byte = rdata[23:16];
      default: ld_byte = rdata[31:24];
    endcase
  end

  assign ld_half = off[1] ? rdata[31:16] : rdata[15:0];

  // extension, zero for anything that is not a legal load
  always_comb begin
    ld_result = '0;
    if (op == op_load && !err) begin
      case (funct3)
        f3_b:    ld_result = {{(data_width-8){ld_byte[7]}}, ld_byte};
        f3_h:    ld_result = {{(data_width-16){ld_half[15]}}, ld_half};
        f3_w:    ld_result = rdata;
        f3_bu:   ld_result = {{(data_width-8){1'b0}}, ld_byte};
        f3_hu:   ld_result = {{(data_width-16){1'b0}}, ld_half};
        default: ld_result = '0;
      endcase
    end
  end

endmodule

//--- lsu_dmem.sv
module lsu_dmem import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  we,
  input  logic [3:0]            be,
  input  logic [mem_aw-1:0]     waddr,
  input  logic [data_width-1:0] wdata,
  input  logic [mem_aw-1:0]     raddr,
  input  logic                  re,
  output logic [data_width-1:0] rdata
);

  logic [data_width-1:0] mem [mem_words];

  // byte-masked write
  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) mem[waddr][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  // registered read, data one cycle after re
  always_ff @(posedge clk) begin
    if (re) rdata <= mem[raddr];
  end

  // the core starts one operation per cycle, so a port clash means a core bug
  a_no_rw_clash: assert property (@(posedge clk) !(we && re))
    else $error("memory write and read enabled in the same cycle");

endmodule

//--- lsu_core.sv
module lsu_core import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cmd_valid,
  output logic                  cmd_ready,
  input  logic [op_w-1:0]       cmd_op,
  input  logic [2:0]            cmd_funct3,
  input  logic [data_width-1:0] cmd_addr,
  input  logic [data_width-1:0] cmd_wdata,
  output logic                  res_valid,
  input  logic                  res_ready,
  output logic [data_width-1:0] res_data,
  output logic                  res_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_load_wait,
    st_hold
  } state_t;

  state_t state;

  logic [op_w-1:0]       al_op;
  logic [2:0]            al_funct3;
  logic [data_width-1:0] al_addr;
  logic [3:0]            wr_be;
  logic [data_width-1:0] wr_data;
  logic [data_width-1:0] ld_result;
  logic                  err;
  logic [data_width-1:0] rdata;
  logic                  we;
  logic                  re;
  logic [2:0]            ld_f3; // kept for the extract cycle
  logic [1:0]            ld_lo;

  // align sees the live command when idle, the saved load otherwise
  assign al_op     = (state == st_idle) ? cmd_op : op_load;
  assign al_funct3 = (state == st_idle) ? cmd_funct3 : ld_f3;
  assign al_addr   = (state == st_idle) ? cmd_addr : {{(data_width-2){1'b0}}, ld_lo};

  lsu_align u_align (
    .op        (al_op),
    .funct3    (al_funct3),
    .addr      (al_addr),
    .wdata     (cmd_wdata),
    .rdata     (rdata),
    .wr_be     (wr_be),
    .wr_data   (wr_data),
    .ld_result (ld_result),
    .err       (err)
  );

  assign we = cmd_valid && (|wr_be);                     // be is zero on error
  assign re = cmd_valid && (cmd_op == op_load) && !err;

  lsu_dmem u_dmem (
    .clk   (clk),
    .we    (we),
    .be    (wr_be),
    .waddr (cmd_addr[mem_aw+1:2]),
    .wdata (wr_data),
    .raddr (cmd_addr[mem_aw+1:2]),
    .re    (re),
    .rdata (rdata)
  );

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (re) state <= st_load_wait;
          else if (cmd_valid) state <= st_hold; // store or illegal op
        end
        st_load_wait: state <= st_hold;
        st_hold: begin
          if (res_ready) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // result payload
  always_ff @(posedge clk) begin
    if (state == st_idle && cmd_valid) begin
      ld_f3    <= cmd_funct3;
      ld_lo    <= cmd_addr[1:0];
      res_data <= '0;
      res_err  <= err;
    end else if (state == st_load_wait) begin
      res_data <= ld_result;
      res_err  <= 1'b0;
    end
  end

  assign cmd_ready = (state == st_idle);
  assign res_valid = (state == st_hold);

  a_cmd_when_ready: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_valid |-> cmd_ready)
    else $error("command issued while the core was busy");

endmodule

//--- lsu_rsp_port.sv
module lsu_rsp_port import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  res_valid,
  output logic                  res_ready,
  input  logic [data_width-1:0] res_data,
  input  logic                  res_err,
  output logic                  rsp_req,
  input  logic                  rsp_ack,
  output logic [data_width-1:0] rsp_data,
  output logic                  rsp_err
);

  typedef enum logic [1:0] {
    st_idle,
    st_send,  // rsp_req high, waiting for ack
    st_drain  // req dropped, waiting for ack to fall
  } state_t;

  state_t state;

  assign res_ready = (state == st_idle);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      case (state)
        st_idle: begin
          if (res_valid) state <= st_send;
        end
        st_send: begin
          if (rsp_ack) state <= st_drain;
        end
        st_drain: begin
          if (!rsp_ack) state <= st_idle;
        end
        default: state <= st_idle;
      endcase
    end
  end

  // capture one result, held through the whole send
  always_ff @(posedge clk) begin
    if (res_ready && res_valid) begin
      rsp_data <= res_data;
      rsp_err  <= res_err;
    end
  end

  assign rsp_req = (state == st_send);

  a_rsp_stable: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_req |=> !rsp_req || ($stable(rsp_data) && $stable(rsp_err)))
    else $error("response payload changed while rsp_req was high");

endmodule

//--- lsu_top.sv
module lsu_top import lsu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  output logic                  ack,
  input  logic [op_w-1:0]       lsu_op,
  input  logic [2:0]            funct3,
  input  logic [data_width-1:0] addr,
  input  logic [data_width-1:0] wdata,
  output logic                  rsp_req,
  input  logic                  rsp_ack,
  output logic [data_width-1:0] rsp_data,
  output logic                  rsp_err
);

  // request port to core
  logic                  cmd_valid;
  logic                  cmd_ready;
  logic [op_w-1:0]       cmd_op;
  logic [2:0]            cmd_funct3;
  logic [data_width-1:0] cmd_addr;
  logic [data_width-1:0] cmd_wdata;

  // core to response port
  logic                  res_valid;
  logic                  res_ready;
  logic [data_width-1:0] res_data;
  logic                  res_err;

  lsu_req_port u_req_port (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        (req),
    .ack        (ack),
    .lsu_op     (lsu_op),
    .funct3     (funct3),
    .addr       (addr),
    .wdata      (wdata),
    .cmd_ready  (cmd_ready),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cmd_funct3 (cmd_funct3),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata)
  );

  lsu_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready),
    .cmd_op     (cmd_op),
    .cmd_funct3 (cmd_funct3),
    .cmd_addr   (cmd_addr),
    .cmd_wdata  (cmd_wdata),
    .res_valid  (res_valid),
    .res_ready  (res_ready),
    .res_data   (res_data),
    .res_err    (res_err)
  );

  lsu_rsp_port u_rsp_port (
    .clk       (clk),
    .rst_n     (rst_n),
    .res_valid (res_valid),
    .res_ready (res_ready),
    .res_data  (res_data),
    .res_err   (res_err),
    .rsp_req   (rsp_req),
    .rsp_ack   (rsp_ack),
    .rsp_data  (rsp_data),
    .rsp_err   (rsp_err)
  );

endmodule

//--- tb_lsu.sv
module tb_lsu import lsu_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_directed  = 45;  // init 8, word 4, merge 21, error 12
  localparam int n_random    = 200;
  localparam int cycle_limit = 40 * (n_directed + n_random) + 100;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  req;
  logic                  ack;
  logic [op_w-1:0]       lsu_op;
  logic [2:0]            funct3;
  logic [data_width-1:0] addr;
  logic [data_width-1:0] wdata;
  logic                  rsp_req;
  logic                  rsp_ack;
  logic [data_width-1:0] rsp_data;
  logic                  rsp_err;

  integer stim_seed = 9;
  integer ack_seed  = 9;  // separate stream for response delays
  logic   req_seen  = 1'b0;
  int     n_checked = 0;

  logic [7:0]            ref_mem [1024]; // byte image of the data memory
  logic [data_width-1:0] exp_data_q [$];
  logic                  exp_err_q [$];

  lsu_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .ack      (ack),
    .lsu_op   (lsu_op),
    .funct3   (funct3),
    .addr     (addr),
    .wdata    (wdata),
    .rsp_req  (rsp_req),
    .rsp_ack  (rsp_ack),
    .rsp_data (rsp_data),
    .rsp_err  (rsp_err)
  );

  always #10 clk = ~clk;

  task automatic fail_stop(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "run stopped at the first failing check");
  endtask

  // one clock plus a small settle delay
  task automatic step();
    @(posedge clk);
    #1;
  endtask

  function automatic logic [data_width-1:0] fill_word(input logic [data_width-1:0] a);
    return a ^ {a[15:0], a[31:16]} ^ 32'h6c3a_91e5;
  endfunction

  // reference result of one operation and its effect on the byte image
  task automatic model_op(input logic [op_w-1:0] op, input logic [2:0] f3,
                          input logic [data_width-1:0] a, input logic [data_width-1:0] wd,
                          output logic [data_width-1:0] data, output logic err);
    int   size;
    int   base;
    logic is_signed;
    logic [data_width-1:0] raw;
    size      = 0;
    is_signed = 1'b1;
    raw       = '0;
    case (f3)
      f3_b:  size = 1;
      f3_h:  size = 2;
      f3_w:  size = 4;
      f3_bu: begin
        size      = 1;
        is_signed = 1'b0;
      end
      f3_hu: begin
        size      = 2;
        is_signed = 1'b0;
      end
      default: size = 0;
    endcase
    if (op == op_store && !is_signed) size = 0; // no unsigned stores
    if (op != op_load && op != op_store) size = 0;
    err  = (size == 0) || (int'(a[1:0]) % size != 0);
    data = '0;
    base = int'(a[9:0]); // word index wraps at 256 words
    if (!err && op == op_store) begin
      for (int i = 0; i < size; i++) ref_mem[base + i] = wd[8*i +: 8];
    end else if (!err) begin
      for (int i = 0; i < size; i++) raw[8*i +: 8] = ref_mem[base + i];
      if (is_signed && size < 4 && raw[8*size-1]) raw = raw | (32'hffff_ffff << (8*size));
      data = raw;
    end
  endtask

  // four-phase request with the expected response queued first
  task automatic do_request(input logic [op_w-1:0] op, input logic [2:0] f3,
                            input logic [data_width-1:0] a, input logic [data_width-1:0] wd);
    logic [data_width-1:0] exp_d;
    logic                  exp_e;
    int                    hold;
    model_op(op, f3, a, wd, exp_d, exp_e);
    exp_data_q.push_back(exp_d);
    exp_err_q.push_back(exp_e);
    lsu_op   = op;
    funct3   = f3;
    addr     = a;
    wdata    = wd;
    req      = 1'b1;
    req_seen = 1'b1;
    do step(); while (!ack);
    hold = $unsigned($random(stim_seed)) % 3; // req may stay up a little after ack
    repeat (hold) step();
    req = 1'b0;
    do step(); while (ack);
  endtask

  task automatic check_response();
    logic [data_width-1:0] exp_d;
    logic                  exp_e;
    if (exp_data_q.size() == 0) fail_stop("a response arrived with no operation outstanding");
    exp_d = exp_data_q.pop_front();
    exp_e = exp_err_q.pop_front();
    if (rsp_err !== exp_e)
      fail_stop($sformatf("** Error: rsp_err expected %h, got %h (response %0d)",
                          exp_e, rsp_err, n_checked));
    if (rsp_data !== exp_d)
      fail_stop($sformatf("** Error: rsp_data expected %h, got %h (response %0d)",
                          exp_d, rsp_data, n_checked));
    n_checked++;
  endtask

  // random operation that is mostly legal and aligned
  task automatic random_op();
    int                    pick;
    logic [op_w-1:0]       op;
    logic [2:0]            f3;
    logic [2:0]            word;
    logic [1:0]            off;
    logic [data_width-1:0] hi;
    pick = $unsigned($random(stim_seed)) % 16;
    if (pick < 7) op = op_store;
    else if (pick < 15) op = op_load;
    else op = op_none;
    pick = $unsigned($random(stim_seed)) % 8;
    case (pick)
      0, 1, 6: f3 = f3_w;
      2:       f3 = f3_h;
      3:       f3 = f3_b;
      4:       f3 = (op == op_load) ? f3_bu : f3_b;
      5:       f3 = (op == op_load) ? f3_hu : f3_h;
      default: f3 = 3'($unsigned($random(stim_seed)) % 8); // any code at all
    endcase
    word = 3'($unsigned($random(stim_seed)) % 8);
    off  = 2'($unsigned($random(stim_seed)) % 4);
    pick = $unsigned($random(stim_seed)) % 4;
    if (pick != 0) begin
      if (f3 == f3_h || f3 == f3_hu) off[0] = 1'b0;
      else if (f3 == f3_w) off = 2'd0;
    end
    hi = $random(stim_seed); // upper bits alias onto the same words
    do_request(op, f3, {hi[21:0], 5'd0, word, off}, $random(stim_seed));
  endtask

  a_idle_after_reset: assert property (@(posedge clk) disable iff (!rst_n)
    !req_seen |-> !ack && !rsp_req)
    else fail_stop("ack or rsp_req went high before any request");

  a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    !ack && !req |=> !ack)
    else fail_stop("ack rose without req being high");

  a_ack_waits_req: assert property (@(posedge clk) disable iff (!rst_n)
    ack && req |=> ack)
    else fail_stop("ack fell while req was still high");

  a_rsp_waits_ack: assert property (@(posedge clk) disable iff (!rst_n)
    rsp_ack && !rsp_req |=> !rsp_req)
    else fail_stop("rsp_req rose again before rsp_ack fell");

  a_rsp_payload_stable: assert property (@(posedge clk) disable iff (!rst_n)
    $past(rsp_req) && rsp_req |-> $stable(rsp_data) && $stable(rsp_err))
    else fail_stop("rsp_data or rsp_err changed while rsp_req was high");

  // consumer answers each rsp_req after 0 to 5 cycles
  initial begin : consumer
    int delay;
    int hold;
    rsp_ack = 1'b0;
    forever begin
      step();
      if (rsp_req) begin
        check_response();
        delay = $unsigned($random(ack_seed)) % 6;
        repeat (delay) step();
        rsp_ack = 1'b1;
        do step(); while (rsp_req);
        hold = $unsigned($random(ack_seed)) % 3; // ack may linger after rsp_req falls
        repeat (hold) step();
        rsp_ack = 1'b0;
      end
    end
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycle_limit) fail_stop("timeout: the operations did not complete in time");
    end
  end

  initial begin : stimulus
    rst_n  = 1'b0;
    req    = 1'b0;
    lsu_op = op_none;
    funct3 = 3'd0;
    addr   = '0;
    wdata  = '0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (3) step(); // quiet window before the first request

    // preload words 0..7 for the random run
    for (int w = 0; w < 8; w++) do_request(op_store, f3_w, 32'(w * 4), fill_word(32'(w * 4)));

    // word store and load back plus an address that wraps
    do_request(op_store, f3_w, 32'h40, 32'hdead_beef);
    do_request(op_load, f3_w, 32'h40, 32'h0);
    do_request(op_store, f3_w, 32'h444, 32'h0bad_c0de);
    do_request(op_load, f3_w, 32'h44, 32'h0);

    // byte lanes merge into one word
    do_request(op_store, f3_w, 32'h80, 32'h0);
    for (int i = 0; i < 4; i++)
      do_request(op_store, f3_b, 32'h80 + 32'(i),
                 {24'ha5a5a5, 8'(32'h74f3_1281 >> (8 * i))});
    do_request(op_load, f3_w, 32'h80, 32'h0);
    for (int i = 0; i < 4; i++) begin
      do_request(op_load, f3_b, 32'h80 + 32'(i), 32'h0);
      do_request(op_load, f3_bu, 32'h80 + 32'(i), 32'h0);
    end

    // halves at both offsets
    do_request(op_store, f3_h, 32'h84, 32'hbeef_8001);
    do_request(op_store, f3_h, 32'h86, 32'h1234_7ffe);
    for (int i = 0; i < 4; i += 2) begin
      do_request(op_load, f3_h, 32'h84 + 32'(i), 32'h0);
      do_request(op_load, f3_hu, 32'h84 + 32'(i), 32'h0);
    end
    do_request(op_load, f3_w, 32'h84, 32'h0);

    // error cases that must leave the word at 0x90 alone
    do_request(op_store, f3_w, 32'h90, 32'hcafe_f00d);
    do_request(op_store, f3_h, 32'h91, 32'h1111_1111);
    do_request(op_store, f3_w, 32'h92, 32'h1111_1111);
    do_request(op_load, f3_h, 32'h93, 32'h0);
    do_request(op_load, f3_w, 32'h91, 32'h0);
    do_request(op_load, f3_hu, 32'h91, 32'h0);
    do_request(op_store, f3_bu, 32'h90, 32'h1111_1111);
    do_request(op_store, f3_hu, 32'h90, 32'h1111_1111);
    do_request(op_store, 3'd3, 32'h90, 32'h1111_1111);
    do_request(op_load, 3'd3, 32'h90, 32'h0);
    do_request(op_none, f3_w, 32'h90, 32'h2222_2222);
    do_request(op_load, f3_w, 32'h90, 32'h0);

    for (int n = 0; n < n_random; n++) random_op();

    // let the last responses drain
    while (exp_data_q.size() != 0 || rsp_req || rsp_ack) step();
    if (n_checked == n_directed + n_random) begin
      $display("Simulation passed");
      $finish;
    end else begin
      fail_stop($sformatf("only %0d of %0d responses were checked",
                          n_checked, n_directed + n_random));
    end
  end

endmodule

//--- tb.f
lsu_pkg.sv
lsu_req_port.sv
lsu_align.sv
lsu_dmem.sv
lsu_core.sv
lsu_rsp_port.sv
lsu_top.sv
tb_lsu.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= tb_lsu
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# build and run, the exit status carries pass or fail
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
